// ==== testbench/backend_vectors.mem ====
// Columns: op rd rs1 rs2 imm expected_we expected_data
// op: 0 add 1 sub 2 and 3 or 4 xor 5 addi 6 lw 7 sw, last line F ends the list
// Registers are zero after reset
0 03 01 02 00000000 1 00000000  // add x3 = x1 + x2
// Constants, one with a negative immediate
5 01 00 00 12345678 1 12345678  // addi x1
5 02 00 00 FFFFFFFB 1 FFFFFFFB  // addi x2 = -5
5 04 00 00 0F0F00FF 1 0F0F00FF  // addi x4
// Register to register ALU ops
0 05 01 02 00000000 1 12345673  // add x5 = x1 + x2
1 06 02 01 00000000 1 EDCBA983  // sub x6 = x2 - x1
1 07 00 01 00000000 1 EDCBA988  // sub x7 = 0 - x1 wraps
2 08 01 04 00000000 1 02040078  // and x8
3 09 01 04 00000000 1 1F3F56FF  // or x9
4 0A 01 04 00000000 1 1D3B5687  // xor x10
// x0 target is dropped
5 00 01 00 00000100 0 12345778  // addi x0 = x1 + 0x100
0 0B 00 00 00000000 1 00000000  // add x11 = x0 + x0
// Stores then loads through other base and offset
5 0C 00 00 00000040 1 00000040  // x12 = 0x40
7 00 0C 05 00000008 0 12345673  // sw x5 to 0x48
7 00 0C 09 00000010 0 1F3F56FF  // sw x9 to 0x50
5 0D 00 00 00000058 1 00000058  // x13 = 0x58
6 0E 0D 00 FFFFFFF0 1 12345673  // lw x14 from 0x58 - 16
6 0F 00 00 00000050 1 1F3F56FF  // lw x15 from 0x50
7 00 00 02 0000004C 0 FFFFFFFB  // sw x2 to 0x4c next to 0x48
6 10 0C 00 0000000C 1 FFFFFFFB  // lw x16 from 0x4c
6 11 0D 00 FFFFFFF0 1 12345673  // lw x17 from 0x48 unchanged
// Loaded values used as operands
0 12 0E 0F 00000000 1 3173AD72  // add x18 = x14 + x15
1 13 05 11 00000000 1 00000000  // sub x19 = x5 - x17
// End of list
F FF FF FF FFFFFFFF F FFFFFFFF

// ==== sources.f ====
common/rapid_isa_pkg.sv
common/rapid_stage_pkg.sv
common/stage_if.sv
source/register_file.sv
execute/execute_stage.sv
memory/memory_stage.sv
writeback/writeback_stage.sv
source/rapid_backend.sv
testbench/rapid_backend_tb.sv

// ==== Makefile ====
# Verilator build for the backend testbench

SIM      := verilator
TOP      := rapid_backend_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES  := $(shell cat $(FILELIST))
BINARY   := $(OBJ_DIR)/V$(TOP)
VECTORS  := testbench/backend_vectors.mem

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BINARY) $(VECTORS)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/rapid_backend_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rapid_backend_tb import rapid_isa_pkg::*; ();

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DMEM_WORDS   = 64;
    // Words per vector line: op rd rs1 rs2 imm we data
    localparam int VEC_FIELDS   = 7;
    localparam int MAX_VECTORS  = 64;
    localparam int F_OP   = 0;
    localparam int F_RD   = 1;
    localparam int F_RS1  = 2;
    localparam int F_RS2  = 3;
    localparam int F_IMM  = 4;
    localparam int F_WE   = 5;
    localparam int F_DATA = 6;
    // Op word of the closing line
    localparam logic [31:0] END_MARK = 32'h0000000F;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_issue_valid;
    logic                   o_issue_ready;
    opcode_t                i_issue_op;
    logic [REG_ADDR_W-1:0]  i_issue_rd;
    logic [REG_ADDR_W-1:0]  i_issue_rs1;
    logic [REG_ADDR_W-1:0]  i_issue_rs2;
    logic [XLEN-1:0]        i_issue_imm;
    logic                   o_retire_valid;
    logic                   o_retire_we;
    logic [REG_ADDR_W-1:0]  o_retire_rd;
    logic [XLEN-1:0]        o_retire_data;

    logic [31:0]    vec_words [VEC_FIELDS*MAX_VECTORS];
    int             num_vectors;
    logic           vectors_loaded;
    logic [31:0]    retire_count;
    int             check_count;

    rapid_backend #(
        .DMEM_WORDS     (DMEM_WORDS)
    ) dut_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_issue_valid  (i_issue_valid),
        .o_issue_ready  (o_issue_ready),
        .i_issue_op     (i_issue_op),
        .i_issue_rd     (i_issue_rd),
        .i_issue_rs1    (i_issue_rs1),
        .i_issue_rs2    (i_issue_rs2),
        .i_issue_imm    (i_issue_imm),
        .o_retire_valid (o_retire_valid),
        .o_retire_we    (o_retire_we),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    ////////////////////////////////////////////////////////////
    // Clock and retire counter
    ////////////////////////////////////////////////////////////

    initial begin
        i_clk = 1'b0;
    end

    always #HALF_PERIOD i_clk = ~i_clk;

    // Counts every retire pulse, stray ones too
    always @(posedge i_clk) begin
        if (i_reset) begin
            retire_count <= '0;
        end else if (o_retire_valid) begin
            retire_count <= retire_count + 32'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] vector_field(input int idx, input int pos);
        return vec_words[idx*VEC_FIELDS + pos];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        if (got !== expected) begin
            $display("error at %0t ns: %s expected 0x%08h got 0x%08h",
                     $time, what, expected, got);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // Entered on a rising edge
    // Valid and fields held until the DUT takes them
    task automatic issue_vector(input int idx);
        logic [31:0] op_word;
        logic [31:0] rd_word;
        logic [31:0] rs1_word;
        logic [31:0] rs2_word;
        op_word  = vector_field(idx, F_OP);
        rd_word  = vector_field(idx, F_RD);
        rs1_word = vector_field(idx, F_RS1);
        rs2_word = vector_field(idx, F_RS2);
        i_issue_valid <= 1'b1;
        i_issue_op    <= opcode_t'(op_word[3:0]);
        i_issue_rd    <= rd_word[REG_ADDR_W-1:0];
        i_issue_rs1   <= rs1_word[REG_ADDR_W-1:0];
        i_issue_rs2   <= rs2_word[REG_ADDR_W-1:0];
        i_issue_imm   <= vector_field(idx, F_IMM);
        // Acceptance edge
        do begin
            @(posedge i_clk);
        end while (!(i_issue_valid && o_issue_ready));
        i_issue_valid <= 1'b0;
    endtask

    task automatic check_retire(input int idx);
        do begin
            @(posedge i_clk);
        end while (o_retire_valid !== 1'b1);
        // Earlier vectors retired once each, nothing more
        check_value($sformatf("vector %0d retire count", idx), retire_count, idx);
        check_value($sformatf("vector %0d retire we", idx),
                    {31'b0, o_retire_we}, vector_field(idx, F_WE));
        check_value($sformatf("vector %0d retire rd", idx),
                    {27'b0, o_retire_rd}, vector_field(idx, F_RD));
        check_value($sformatf("vector %0d retire data", idx),
                    o_retire_data, vector_field(idx, F_DATA));
        // Ready comes back two edges after retire
        check_value($sformatf("vector %0d ready while busy", idx),
                    {31'b0, o_issue_ready}, 32'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        i_reset       <= 1'b1;
        i_issue_valid <= 1'b0;
        i_issue_op    <= OP_ADD;
        i_issue_rd    <= '0;
        i_issue_rs1   <= '0;
        i_issue_rs2   <= '0;
        i_issue_imm   <= '0;
        vectors_loaded = 1'b0;
        check_count    = 0;
        $readmemh("testbench/backend_vectors.mem", vec_words);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vector_field(num_vectors, F_OP) !== END_MARK) begin
            num_vectors++;
        end
        if (num_vectors == 0 || num_vectors == MAX_VECTORS) begin
            $display("vector file is empty or has no end marker");
            $display("*** FAILED ***");
            $fatal(1, "bad vector file");
        end
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);
        // Idle out of reset
        check_value("ready after reset", {31'b0, o_issue_ready}, 32'd1);
        check_value("retire valid after reset", {31'b0, o_retire_valid}, 32'd0);
        check_value("retire we after reset", {31'b0, o_retire_we}, 32'd0);
        for (int idx = 0; idx < num_vectors; idx++) begin
            issue_vector(idx);
            check_retire(idx);
        end
        // Room for a late extra retire to show up
        repeat (10) @(posedge i_clk);
        check_value("total retires", retire_count, num_vectors);
        if (check_count > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("no checks were run");
            $display("*** FAILED ***");
            $fatal(1, "empty run");
        end
    end

    // Watchdog, sized from the vector count
    initial begin
        int limit_cycles;
        wait (vectors_loaded === 1'b1);
        limit_cycles = num_vectors * 10 + 100;
        repeat (limit_cycles) @(posedge i_clk);
        $display("timeout: retire never arrived within %0d cycles", limit_cycles);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== source/rapid_backend.sv ====
`timescale 1ns/100ps
`default_nettype none

module rapid_backend import rapid_isa_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    // Issue port
    input  wire logic                   i_issue_valid,
    output logic                        o_issue_ready,
    input  opcode_t                     i_issue_op,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rd,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rs1,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rs2,
    input  wire logic [XLEN-1:0]        i_issue_imm,
    // Retire port
    output logic                        o_retire_valid,
    output logic                        o_retire_we,
    output logic [REG_ADDR_W-1:0]       o_retire_rd,
    output logic [XLEN-1:0]             o_retire_data
);

    // Register file read nets
    logic [REG_ADDR_W-1:0]  rs1_addr;
    logic [REG_ADDR_W-1:0]  rs2_addr;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    // Register file write nets
    logic                   rf_we;
    logic [REG_ADDR_W-1:0]  rf_rd;
    logic [XLEN-1:0]        rf_data;
    // Retire complete
    logic                   wb_done;

    stage_if ex_to_mem ();
    stage_if mem_to_wb ();

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    execute_stage u_execute (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_issue_valid  (i_issue_valid),
        .i_issue_op     (i_issue_op),
        .i_issue_rd     (i_issue_rd),
        .i_issue_rs1    (i_issue_rs1),
        .i_issue_rs2    (i_issue_rs2),
        .i_issue_imm    (i_issue_imm),
        .o_issue_ready  (o_issue_ready),
        .o_rs1_addr     (rs1_addr),
        .o_rs2_addr     (rs2_addr),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_wb_done      (wb_done),
        .out_if         (ex_to_mem.src)
    );

    memory_stage #(
        .DMEM_WORDS     (DMEM_WORDS)
    ) u_memory (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .in_if          (ex_to_mem.dst),
        .out_if         (mem_to_wb.src)
    );

    writeback_stage u_writeback (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .in_if          (mem_to_wb.dst),
        .o_rf_we        (rf_we),
        .o_rf_rd        (rf_rd),
        .o_rf_data      (rf_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_we    (o_retire_we),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_done         (wb_done)
    );

    // Shared integer registers
    register_file u_regfile (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rs1_addr     (rs1_addr),
        .i_rs2_addr     (rs2_addr),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .i_we           (rf_we),
        .i_rd           (rf_rd),
        .i_wd           (rf_data)
    );

endmodule

`default_nettype wire

// ==== writeback/writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage import rapid_isa_pkg::*, rapid_stage_pkg::*; (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    stage_if.dst                        in_if,
    // Register file write port
    output logic                        o_rf_we,
    output logic [REG_ADDR_W-1:0]       o_rf_rd,
    output logic [XLEN-1:0]             o_rf_data,
    // Retire report
    output logic                        o_retire_valid,
    output logic                        o_retire_we,
    output logic [REG_ADDR_W-1:0]       o_retire_rd,
    output logic [XLEN-1:0]             o_retire_data,
    // Back to execute
    output logic                        o_done
);

    wb_state_t          state;
    control_s           ctrl_q;
    logic [XLEN-1:0]    data_q;
    logic               write_en;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            state  <= WB_RESET;
            ctrl_q <= control_s_default();
        end else begin
            case (state)
                WB_RESET: state <= WB_WAIT;
                WB_WAIT: begin
                    if (in_if.valid) begin
                        ctrl_q <= in_if.ctrl;
                        state  <= WB_WRITE;
                    end
                end
                WB_WRITE: state <= WB_DONE;
                WB_DONE:  state <= WB_WAIT;
                default:  state <= WB_RESET;
            endcase
        end
    end

    // Retire payload
    always_ff @(posedge i_clk) begin
        if (state == WB_WAIT && in_if.valid) begin
            data_q <= in_if.result;
        end
    end

    // Stores and x0 targets leave the register file alone
    assign write_en = (state == WB_WRITE) && ctrl_q.reg_write && (ctrl_q.rd != '0);

    assign o_rf_we   = write_en;
    assign o_rf_rd   = ctrl_q.rd;
    assign o_rf_data = data_q;

    assign o_retire_valid = (state == WB_WRITE);
    assign o_retire_we    = write_en;
    assign o_retire_rd    = ctrl_q.rd;
    assign o_retire_data  = data_q;

    // Frees execute for the next issue
    assign o_done = (state == WB_DONE);

    // Memory only hands on while this stage is waiting
    a_handoff_when_waiting: assert property (@(posedge i_clk) disable iff (i_reset)
        in_if.valid |-> state == WB_WAIT);

endmodule

`default_nettype wire

// ==== memory/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage import rapid_isa_pkg::*, rapid_stage_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic   i_clk,
    input  wire logic   i_reset,
    stage_if.dst        in_if,
    stage_if.src        out_if
);

    localparam int WADDR_W = $clog2(DMEM_WORDS);

    mem_state_t         state;
    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [WADDR_W-1:0] word_addr;
    logic [XLEN-1:0]    load_word;

    // Byte address to word index
    assign word_addr = in_if.result[WADDR_W+1:2];
    assign load_word = dmem[word_addr];

    ////////////////////////////////////////////////////////////
    // Strobe sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (in_if.valid) begin
                        state <= MEM_ACCESS;
                    end
                end
                // Output strobe lasts one cycle
                MEM_ACCESS: state <= MEM_IDLE;
                default:    state <= MEM_IDLE;
            endcase
        end
    end

    assign out_if.valid = (state == MEM_ACCESS);

    ////////////////////////////////////////////////////////////
    // Data array and result select
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (in_if.valid) begin
            out_if.ctrl       <= in_if.ctrl;
            out_if.store_data <= in_if.store_data;
            if (in_if.ctrl.mem_write) begin
                dmem[word_addr] <= in_if.store_data;
                // Store reports the value written
                out_if.result   <= in_if.store_data;
            end else if (in_if.ctrl.mem_read) begin
                out_if.result   <= load_word;
            end else begin
                // ALU result passes through
                out_if.result   <= in_if.result;
            end
        end
    end

    // Address from execute must be word aligned
    a_word_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        in_if.valid && (in_if.ctrl.mem_read || in_if.ctrl.mem_write)
        |-> in_if.result[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rapid_isa_pkg::*, rapid_stage_pkg::*; (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    // Issue port
    input  wire logic                   i_issue_valid,
    input  opcode_t                     i_issue_op,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rd,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rs1,
    input  wire logic [REG_ADDR_W-1:0]  i_issue_rs2,
    input  wire logic [XLEN-1:0]        i_issue_imm,
    output logic                        o_issue_ready,
    // Register file read side
    output logic [REG_ADDR_W-1:0]       o_rs1_addr,
    output logic [REG_ADDR_W-1:0]       o_rs2_addr,
    input  wire logic [XLEN-1:0]        i_rs1_data,
    input  wire logic [XLEN-1:0]        i_rs2_data,
    // Retire finished
    input  wire logic                   i_wb_done,
    stage_if.src                        out_if
);

    ex_state_t          state;
    control_s           ctrl_q;
    logic [XLEN-1:0]    alu_result;
    logic               issue_fire;

    // Only one operation in flight
    assign o_issue_ready = (state == EX_IDLE);
    assign issue_fire    = i_issue_valid && o_issue_ready;

    // Source indices come from the captured op
    assign o_rs1_addr = ctrl_q.rs1;
    assign o_rs2_addr = ctrl_q.rs2;

    ////////////////////////////////////////////////////////////
    // FSM and issue capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            state        <= EX_IDLE;
            ctrl_q       <= control_s_default();
            out_if.valid <= 1'b0;
        end else begin
            out_if.valid <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (issue_fire) begin
                        ctrl_q <= control_from_op(i_issue_op, i_issue_rd, i_issue_rs1,
                                                  i_issue_rs2, i_issue_imm);
                        state  <= EX_RUN;
                    end
                end
                EX_RUN: begin
                    // Hand on after one compute cycle
                    out_if.valid <= 1'b1;
                    state        <= EX_WAIT;
                end
                EX_WAIT: begin
                    if (i_wb_done) begin
                        state <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Result payload, captured at the end of the run cycle
    always_ff @(posedge i_clk) begin
        if (state == EX_RUN) begin
            out_if.result     <= alu_result;
            out_if.store_data <= i_rs2_data;
        end
    end

    // ctrl_q is stable until the next acceptance
    assign out_if.ctrl = ctrl_q;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl_q.op)
            OP_ADD:  alu_result = i_rs1_data + i_rs2_data;
            // Wraps mod 2^32
            OP_SUB:  alu_result = i_rs1_data - i_rs2_data;
            OP_AND:  alu_result = i_rs1_data & i_rs2_data;
            OP_OR:   alu_result = i_rs1_data | i_rs2_data;
            OP_XOR:  alu_result = i_rs1_data ^ i_rs2_data;
            OP_ADDI: alu_result = i_rs1_data + ctrl_q.imm;
            // Effective address for memory ops
            OP_LW,
            OP_SW:   alu_result = i_rs1_data + ctrl_q.imm;
            default: alu_result = '0;
        endcase
    end

    // No new issue for four edges after an acceptance
    // Spacing depends on the done pulse from writeback
    a_issue_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
        issue_fire |-> state == EX_IDLE ##1 !issue_fire ##1 !issue_fire
                       ##1 !issue_fire ##1 !issue_fire);

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file import rapid_isa_pkg::*; (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    // Read ports, combinational
    input  wire logic [REG_ADDR_W-1:0]  i_rs1_addr,
    input  wire logic [REG_ADDR_W-1:0]  i_rs2_addr,
    output logic [XLEN-1:0]             o_rs1_data,
    output logic [XLEN-1:0]             o_rs2_data,
    // Write port
    input  wire logic                   i_we,
    input  wire logic [REG_ADDR_W-1:0]  i_rd,
    input  wire logic [XLEN-1:0]        i_wd
);

    logic [XLEN-1:0] regs [REG_COUNT];

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            // All registers start at zero
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // x0 is never written so it keeps reading zero
            if (i_we && (i_rd != '0)) begin
                regs[i_rd] <= i_wd;
            end
        end
    end

    // Asynchronous reads
    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

endmodule

`default_nettype wire

// ==== common/stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Hand-off between two stages, no ready since the sink is always idle
interface stage_if import rapid_isa_pkg::*; ();

    // One-cycle strobe
    logic               valid;
    // Held stable while valid is high
    control_s           ctrl;
    logic [XLEN-1:0]    result;
    logic [XLEN-1:0]    store_data;

    // Producing stage
    modport src (
        output valid,
        output ctrl,
        output result,
        output store_data
    );

    // Consuming stage
    modport dst (
        input  valid,
        input  ctrl,
        input  result,
        input  store_data
    );

endinterface

`default_nettype wire

// ==== common/rapid_stage_pkg.sv ====
`default_nettype none

package rapid_stage_pkg;

    ////////////////////////////////////////////////////////////
    // Stage FSM encodings
    ////////////////////////////////////////////////////////////

    // Execute: idle, compute one cycle, hold until retire done
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_RUN,
        EX_WAIT
    } ex_state_t;

    // Memory: ACCESS is the cycle the output strobe is high
    typedef enum logic {
        MEM_IDLE,
        MEM_ACCESS
    } mem_state_t;

    // Writeback sequence
    typedef enum logic [1:0] {
        WB_RESET,
        WB_WAIT,
        WB_WRITE,
        WB_DONE
    } wb_state_t;

endpackage

`default_nettype wire

// ==== common/rapid_isa_pkg.sv ====
`default_nettype none

package rapid_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Architectural sizes
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // Operation codes seen at the issue port
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7
    } opcode_t;

    // Decoded operation, carried down the stages
    typedef struct packed {
        opcode_t                  op;
        logic [REG_ADDR_W-1:0]    rd;
        logic [REG_ADDR_W-1:0]    rs1;
        logic [REG_ADDR_W-1:0]    rs2;
        logic signed [XLEN-1:0]   imm;
        logic                     mem_read;
        logic                     mem_write;
        logic                     reg_write;
    } control_s;

    // Build control word, flags follow the opcode
    function automatic control_s control_from_op(
        input opcode_t               op,
        input logic [REG_ADDR_W-1:0] rd,
        input logic [REG_ADDR_W-1:0] rs1,
        input logic [REG_ADDR_W-1:0] rs2,
        input logic [XLEN-1:0]       imm
    );
        control_s c;
        c.op        = op;
        c.rd        = rd;
        c.rs1       = rs1;
        c.rs2       = rs2;
        c.imm       = imm;
        c.mem_read  = (op == OP_LW);
        c.mem_write = (op == OP_SW);
        // Everything but a store targets rd
        c.reg_write = (op != OP_SW);
        return c;
    endfunction

    // All-clear control word
    function automatic control_s control_s_default();
        control_s c;
        c = '0;
        return c;
    endfunction

endpackage

`default_nettype wire
